// File: project.f
stream_pkg.sv
register_slice_backpressure.sv
register_slice_datapath.sv
register_slice.sv
stream_tagger.sv
stream_pipe.sv
tb_clock_gen.sv
tb_stream_pipe.sv

// File: register_slice.sv
`timescale 1ns/1ps

module register_slice #(
    parameter bit     ENABLE_BACKPRESSURE = 1'b1,  // cut ready path
    parameter bit     ENABLE_DATAPATH     = 1'b1,  // cut valid/data path
    parameter type    DAT_TYP = logic [8-1:0],     // payload type
    parameter DAT_TYP DAT_RST = DAT_TYP'('x),      // payload reset value
    parameter bit     LOW_PWR = 1'b1               // gate idle data loads
)(
    input  logic   clk,
    input  logic   rst_n,
    // receive side
    input  logic   rx_vld,
    input  DAT_TYP rx_dat,
    output logic   rx_rdy,
    // transmit side
    output logic   tx_vld,
    output DAT_TYP tx_dat,
    input  logic   tx_rdy
);

    // stream between the two stages
    logic   md_vld;
    DAT_TYP md_dat;
    logic   md_rdy;

    //////////////////////////////////////////////////
    // ready path stage
    //////////////////////////////////////////////////

    generate
        if (ENABLE_BACKPRESSURE) begin : gen_bp
            register_slice_backpressure #(
                .DAT_TYP (DAT_TYP),
                .DAT_RST (DAT_RST),
                .LOW_PWR (LOW_PWR)
            ) backpressure (
                .clk    (clk),
                .rst_n  (rst_n),
                .rx_vld (rx_vld),
                .rx_dat (rx_dat),
                .rx_rdy (rx_rdy),
                .tx_vld (md_vld),
                .tx_dat (md_dat),
                .tx_rdy (md_rdy)
            );
        end else begin : gen_bp_bypass
            assign md_vld = rx_vld;  // wire through, ready stays combinational
            assign md_dat = rx_dat;
            assign rx_rdy = md_rdy;
        end
    endgenerate

    //////////////////////////////////////////////////
    // valid/data path stage
    //////////////////////////////////////////////////

    generate
        if (ENABLE_DATAPATH) begin : gen_dp
            register_slice_datapath #(
                .DAT_TYP (DAT_TYP),
                .DAT_RST (DAT_RST),
                .LOW_PWR (LOW_PWR)
            ) datapath (
                .clk    (clk),
                .rst_n  (rst_n),
                .rx_vld (md_vld),
                .rx_dat (md_dat),
                .rx_rdy (md_rdy),
                .tx_vld (tx_vld),
                .tx_dat (tx_dat),
                .tx_rdy (tx_rdy)
            );
        end else begin : gen_dp_bypass
            assign tx_vld = md_vld;  // zero latency
            assign tx_dat = md_dat;
            assign md_rdy = tx_rdy;
        end
    endgenerate

endmodule: register_slice

// File: register_slice_backpressure.sv
`timescale 1ns/1ps

module register_slice_backpressure #(
    parameter type    DAT_TYP = logic [8-1:0],  // payload type
    parameter DAT_TYP DAT_RST = DAT_TYP'('x),   // skid reset value, 'x means none
    parameter bit     LOW_PWR = 1'b1            // load skid only when needed
)(
    input  logic   clk,
    input  logic   rst_n,
    // receive side
    input  logic   rx_vld,
    input  DAT_TYP rx_dat,
    output logic   rx_rdy,
    // transmit side
    output logic   tx_vld,
    output DAT_TYP tx_dat,
    input  logic   tx_rdy
);

    import stream_pkg::*;

    skid_state_t state;     // skid occupancy
    DAT_TYP      skid_dat;  // stalled beat
    logic        skid_ld;   // skid load enable

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    // rx_rdy is its own flop, so the upstream ready path is cut here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= SKID_EMPTY;
            rx_rdy <= 1'b1;  // accept right after reset
        end else begin
            case (state)
                SKID_EMPTY: begin
                    if (rx_vld && !tx_rdy) begin  // beat taken, tx stalled
                        state  <= SKID_FULL;
                        rx_rdy <= 1'b0;
                    end
                end
                SKID_FULL: begin
                    if (tx_rdy) begin  // stored beat leaves
                        state  <= SKID_EMPTY;
                        rx_rdy <= 1'b1;
                    end
                end
                default: begin
                    state  <= SKID_EMPTY;
                    rx_rdy <= 1'b1;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // skid register
    //////////////////////////////////////////////////

    // low power: only on a stalled accept, else follow rx while empty
    assign skid_ld = LOW_PWR ? (rx_vld && rx_rdy && !tx_rdy) : rx_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_dat <= DAT_RST;
        end else if (skid_ld) begin
            skid_dat <= rx_dat;
        end
    end

    // empty: zero latency pass through
    always_comb begin
        if (state == SKID_FULL) begin
            tx_vld = 1'b1;
            tx_dat = skid_dat;
        end else begin
            tx_vld = rx_vld;
            tx_dat = rx_dat;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // ready flop must agree with the state flop
    a_full_blocks_rx: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SKID_FULL) |-> !rx_rdy);

    // held beat does not change while tx waits
    a_full_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SKID_FULL && !tx_rdy) |=> (tx_vld && $stable(tx_dat)));

endmodule: register_slice_backpressure

// File: register_slice_datapath.sv
`timescale 1ns/1ps

module register_slice_datapath #(
    parameter type    DAT_TYP = logic [8-1:0],  // payload type
    parameter DAT_TYP DAT_RST = DAT_TYP'('x),   // data reset value, 'x means none
    parameter bit     LOW_PWR = 1'b1            // load data on transfer only
)(
    input  logic   clk,
    input  logic   rst_n,
    // receive side
    input  logic   rx_vld,
    input  DAT_TYP rx_dat,
    output logic   rx_rdy,
    // transmit side
    output logic   tx_vld,
    output DAT_TYP tx_dat,
    input  logic   tx_rdy
);

    logic dat_ld;  // data register enable

    // free slot now, or the slot empties this cycle
    assign rx_rdy = !tx_vld || tx_rdy;

    //////////////////////////////////////////////////
    // valid
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_vld <= 1'b0;
        end else if (rx_rdy) begin
            tx_vld <= rx_vld;  // refill or go empty
        end
    end

    //////////////////////////////////////////////////
    // data
    //////////////////////////////////////////////////

    // without low power, idle data also ripples through
    assign dat_ld = LOW_PWR ? (rx_vld && rx_rdy) : rx_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_dat <= DAT_RST;
        end else if (dat_ld) begin
            tx_dat <= rx_dat;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // stalled output holds valid and data
    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_vld && !tx_rdy) |=> (tx_vld && $stable(tx_dat)));

endmodule: register_slice_datapath

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stream pipe testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_stream_pipe

if ! verilator --binary --timing --assert -f project.f --top-module "$TOP" -o "$TOP"; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    echo "run ok"
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi

// File: stream_pipe.sv
`timescale 1ns/1ps

module stream_pipe (
    input  logic                     clk,
    input  logic                     rst_n,
    // raw beats in
    input  logic                     rx_vld,
    input  stream_pkg::stream_beat_t rx_dat,
    output logic                     rx_rdy,
    // tagged beats out
    output logic                     tx_vld,
    output stream_pkg::tagged_beat_t tx_dat,
    input  logic                     tx_rdy
);

    import stream_pkg::*;

    // input slice -> tagger
    logic         in_vld;
    stream_beat_t in_dat;
    logic         in_rdy;

    // tagger -> output slice
    logic         tag_vld;
    tagged_beat_t tag_dat;
    logic         tag_rdy;

    //////////////////////////////////////////////////
    // input slice, both registers
    //////////////////////////////////////////////////

    register_slice #(
        .ENABLE_BACKPRESSURE (1'b1),
        .ENABLE_DATAPATH     (1'b1),
        .DAT_TYP             (stream_beat_t)
    ) u_in_slice (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_vld (rx_vld),
        .rx_dat (rx_dat),
        .rx_rdy (rx_rdy),   // registered ready to the source
        .tx_vld (in_vld),
        .tx_dat (in_dat),
        .tx_rdy (in_rdy)
    );

    stream_tagger u_tagger (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_vld (in_vld),
        .rx_dat (in_dat),
        .rx_rdy (in_rdy),
        .tx_vld (tag_vld),
        .tx_dat (tag_dat),
        .tx_rdy (tag_rdy)
    );

    //////////////////////////////////////////////////
    // output slice, datapath only
    //////////////////////////////////////////////////

    register_slice #(
        .ENABLE_BACKPRESSURE (1'b0),
        .ENABLE_DATAPATH     (1'b1),
        .DAT_TYP             (tagged_beat_t)
    ) u_out_slice (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_vld (tag_vld),
        .rx_dat (tag_dat),
        .rx_rdy (tag_rdy),
        .tx_vld (tx_vld),
        .tx_dat (tx_dat),
        .tx_rdy (tx_rdy)
    );

endmodule: stream_pipe

// File: stream_pkg.sv
package stream_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int unsigned DATA_W = 8;  // payload byte
    localparam int unsigned SEQ_W  = 8;  // packet number, wraps at 256
    localparam int unsigned IDX_W  = 4;  // beat index in packet, wraps at 16

    //////////////////////////////////////////////////
    // beat types
    //////////////////////////////////////////////////

    // raw input beat
    typedef struct packed {
        logic [DATA_W-1:0] data;  // payload
        logic              last;  // end of packet
    } stream_beat_t;

    // beat after the tagger
    // seq/idx sit in the upper bits, payload below
    typedef struct packed {
        logic [SEQ_W-1:0]  seq;   // packet sequence number
        logic [IDX_W-1:0]  idx;   // beat position in packet
        logic [DATA_W-1:0] data;  // payload, untouched
        logic              last;  // end of packet, untouched
    } tagged_beat_t;

    //////////////////////////////////////////////////
    // slice state
    //////////////////////////////////////////////////

    // one entry skid buffer occupancy
    typedef enum logic {
        SKID_EMPTY = 1'b0,  // pass through, rx_rdy high
        SKID_FULL  = 1'b1   // holding a stalled beat
    } skid_state_t;

endpackage: stream_pkg

// File: stream_tagger.sv
`timescale 1ns/1ps

module stream_tagger (
    input  logic                     clk,
    input  logic                     rst_n,
    // raw beats in
    input  logic                     rx_vld,
    input  stream_pkg::stream_beat_t rx_dat,
    output logic                     rx_rdy,
    // tagged beats out
    output logic                     tx_vld,
    output stream_pkg::tagged_beat_t tx_dat,
    input  logic                     tx_rdy
);

    import stream_pkg::*;

    logic [SEQ_W-1:0]  seq_cnt;    // current packet number
    logic [IDX_W-1:0]  idx_cnt;    // current beat in packet
    logic [DATA_W-1:0] beat_data;  // payload copy
    logic              xfer;       // handshake this cycle

    //////////////////////////////////////////////////
    // handshake, zero latency
    //////////////////////////////////////////////////

    assign tx_vld = rx_vld;
    assign rx_rdy = tx_rdy;
    assign xfer   = rx_vld && rx_rdy;

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_cnt <= '0;
            idx_cnt <= '0;
        end else if (xfer) begin
            if (rx_dat.last) begin
                seq_cnt <= seq_cnt + 1'b1;  // next packet, wraps
                idx_cnt <= '0;              // restart index
            end else begin
                idx_cnt <= idx_cnt + 1'b1;  // wraps at 16
            end
        end
    end

    //////////////////////////////////////////////////
    // output beat
    //////////////////////////////////////////////////

    assign beat_data = rx_dat.data;

    always_comb begin
        tx_dat.seq  = seq_cnt;
        tx_dat.idx  = idx_cnt;
        tx_dat.data = beat_data;
        tx_dat.last = rx_dat.last;
    end

    // new packet always starts at index 0
    a_idx_clear: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && rx_dat.last) |=> (idx_cnt == '0));

endmodule: stream_tagger

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // free running clock, 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset low over the first 3 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;  // release just after the edge
    end

endmodule: tb_clock_gen

// File: tb_stream_pipe.sv
`timescale 1ns/1ps

module tb_stream_pipe;

    import stream_pkg::*;

    localparam int          N_RANDOM     = 2000;                  // back-pressure run
    localparam int          N_BURST      = 64;                    // full rate run
    localparam int          N_BEATS      = 1 + N_BURST + N_RANDOM;
    localparam int          LIMIT        = 10 * N_BEATS + 100;    // cycle budget
    localparam int          DRAIN_CYCLES = 8;                     // three held beats, tx_rdy high
    localparam logic [15:0] LFSR_SEED    = 16'(71457);            // folded to 16 bits

    logic         clk;
    logic         rst_n;
    logic         rx_vld;
    stream_beat_t rx_dat;
    logic         rx_rdy;
    logic         tx_vld;
    tagged_beat_t tx_dat;
    logic         tx_rdy;

    stream_beat_t     exp_q[$];            // accepted but not yet seen on tx
    logic [SEQ_W-1:0] ref_seq;             // model packet number
    logic [IDX_W-1:0] ref_idx;             // model beat index
    logic [15:0]      lfsr = LFSR_SEED;
    bit               tx_random = 1'b0;    // random tx_rdy when set
    int               cycle = 0;
    int               last_rx_cycle = 0;
    int               last_tx_cycle = 0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    stream_pipe u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_vld (rx_vld),
        .rx_dat (rx_dat),
        .rx_rdy (rx_rdy),
        .tx_vld (tx_vld),
        .tx_dat (tx_dat),
        .tx_rdy (tx_rdy)
    );

    //////////////////////////////////////////////////
    // model and checks
    //////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // expected output beat for one input beat at the given counters
    function automatic tagged_beat_t tag_ref(input stream_beat_t beat,
                                             input logic [SEQ_W-1:0] seq,
                                             input logic [IDX_W-1:0] idx);
        tagged_beat_t t;
        t.seq  = seq;
        t.idx  = idx;
        t.data = beat.data;  // payload passes untouched
        t.last = beat.last;
        return t;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at cycle %0d", cycle);
    endtask

    task automatic check_beat(input string name, input tagged_beat_t got,
                              input tagged_beat_t exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // sampled at negedge between the drive and the next clock edge
    always @(negedge clk) begin : monitor
        stream_beat_t beat;
        if (!rst_n) begin
            ref_seq = '0;
            ref_idx = '0;
        end else if (tx_vld && tx_rdy) begin
            if (exp_q.size() == 0) begin
                fail_run("an output beat left the pipe with no input beat pending");
            end else begin
                beat = exp_q.pop_front();
                check_beat("tx_dat", tx_dat, tag_ref(beat, ref_seq, ref_idx));
                if (beat.last) begin  // next packet
                    ref_seq = ref_seq + 8'd1;
                    ref_idx = '0;
                end else begin
                    ref_idx = ref_idx + 4'd1;
                end
                last_tx_cycle = cycle;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT)
            fail_run($sformatf("timeout, the run did not finish in %0d cycles", LIMIT));
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // advance to 1 ns after the next edge and draw tx_rdy if random
    task automatic step();
        logic [15:0] r;
        @(posedge clk);
        #1;
        if (tx_random) begin
            take_bits(1, r);
            tx_rdy = r[0];
        end
    endtask

    // hold the beat until rx_rdy takes it
    task automatic send_beat(input stream_beat_t beat);
        logic acc;
        rx_vld = 1'b1;
        rx_dat = beat;
        do begin
            @(negedge clk);
            acc = rx_rdy;
            if (acc) begin
                exp_q.push_back(beat);
                last_rx_cycle = cycle;
            end
            step();
        end while (!acc);
        rx_vld = 1'b0;
    endtask

    // step until every accepted beat has left or the budget runs out
    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            step();
            n++;
        end
    endtask

    initial begin : driver
        stream_beat_t beat;
        logic [15:0]  r;
        int           burst_start;
        rx_vld = 1'b0;
        rx_dat = '0;
        tx_rdy = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);  // first cycle out of reset
        check_bit("tx_vld", tx_vld, 1'b0);
        check_bit("rx_rdy", rx_rdy, 1'b1);
        step();

        // single beat with 2 cycle latency
        beat.data = 8'ha5;
        beat.last = 1'b1;
        send_beat(beat);
        wait_drain(LIMIT);
        if (last_tx_cycle - last_rx_cycle != 2)
            fail_run($sformatf("single beat took %0d cycles from rx to tx instead of 2",
                               last_tx_cycle - last_rx_cycle));

        // full rate burst without gaps
        burst_start = 0;
        for (int i = 0; i < N_BURST; i++) begin
            take_bits(8, r);
            beat.data = r[7:0];
            take_bits(5, r);
            beat.last = (r < 16'd5);  // about one in six
            send_beat(beat);
            if (i == 0)
                burst_start = last_rx_cycle;
        end
        if (last_rx_cycle - burst_start != N_BURST - 1)
            fail_run("rx side stalled during the full rate burst");
        wait_drain(LIMIT);
        if (last_tx_cycle - burst_start != N_BURST + 1)
            fail_run("tx side did not deliver one beat per cycle during the burst");

        // random gaps and random tx stalls
        tx_random = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            take_bits(2, r);
            if (r == 16'd0)
                step();  // idle cycle on rx
            take_bits(8, r);
            beat.data = r[7:0];
            take_bits(5, r);
            beat.last = (r < 16'd5);
            send_beat(beat);
        end
        tx_random = 1'b0;
        tx_rdy    = 1'b1;
        wait_drain(DRAIN_CYCLES);
        repeat (10) step();  // nothing extra may come out

        if (exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d accepted beats never left the pipe", exp_q.size()));
        end
    end

endmodule: tb_stream_pipe
